/* files.f */
verilog/uart_link_pkg.sv
verilog/cmd_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/cmd_arbiter.sv
verilog/uart_cmd_master.sv
verilog/uart_cmd_top.sv
tests/uart_cmd_checker.sv
tests/tb_uart_cmd.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_uart_cmd -o sim_uart_cmd
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_uart_cmd)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

/* tests/tb_uart_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd;
  import cmd_pkg::*;

  localparam int clks_per_bit = 8;
  localparam int gap_cycles   = 5;
  localparam int resp_timeout = 400;
  localparam int num_cmds     = 40;
  localparam int cycle_limit  = 2 * num_cmds * 1000;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd_in_0;
  cmd_t       cmd_in_1;
  logic       cmd_vld_0;
  logic       cmd_vld_1;
  logic       cmd_ack_0;
  logic       cmd_ack_1;
  logic       read_rdy_0;
  logic       read_rdy_1;
  logic       read_err_0;
  logic       read_err_1;
  logic [7:0] read_data_0;
  logic [7:0] read_data_1;
  logic       rx;
  logic       tx;
  logic       reply_bad;
  logic       reply_silent;
  int         errors;
  int         checked;
  int         cycles;
  integer     seed;
  logic [7:0] dev_regs [128];

  uart_cmd_top #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles),
    .resp_timeout (resp_timeout)
  ) uart_cmd_top_i (
    .clk (clk), .rst_n (rst_n),
    .cmd_in_0 (cmd_in_0), .cmd_in_1 (cmd_in_1),
    .cmd_vld_0 (cmd_vld_0), .cmd_vld_1 (cmd_vld_1),
    .cmd_ack_0 (cmd_ack_0), .cmd_ack_1 (cmd_ack_1),
    .read_rdy_0 (read_rdy_0), .read_rdy_1 (read_rdy_1),
    .read_err_0 (read_err_0), .read_err_1 (read_err_1),
    .read_data_0 (read_data_0), .read_data_1 (read_data_1),
    .rx (rx), .tx (tx)
  );

  uart_cmd_checker #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles)
  ) checker_i (
    .clk (clk), .rst_n (rst_n), .tx (tx),
    .cmd_in_0 (cmd_in_0), .cmd_in_1 (cmd_in_1),
    .cmd_vld_0 (cmd_vld_0), .cmd_vld_1 (cmd_vld_1),
    .cmd_ack_0 (cmd_ack_0), .cmd_ack_1 (cmd_ack_1),
    .read_rdy_0 (read_rdy_0), .read_rdy_1 (read_rdy_1),
    .read_err_0 (read_err_0), .read_err_1 (read_err_1),
    .read_data_0 (read_data_0), .read_data_1 (read_data_1),
    .reply_bad (reply_bad), .reply_silent (reply_silent),
    .errors (errors), .checked (checked)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout after %0d cycles with %0d commands checked", cycles, checked);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // one host port, a read blocks until its result comes back.
  task automatic issue_cmds(input logic p);
    cmd_t        c;
    int unsigned idle;
    begin
      for (int n = 0; n < num_cmds; n++)
      begin
        idle = $unsigned($random(seed)) % 20;
        repeat (idle) @(negedge clk);
        c = 16'($random(seed));
        c[11] = 1'b0;  // keep addresses in a small window so reads hit writes.
        c[12] = 1'b0;
        c[13] = 1'b0;
        c[14] = 1'b0;
        if (p)
        begin
          cmd_in_1  = c;
          cmd_vld_1 = 1'b1;
        end
        else
        begin
          cmd_in_0  = c;
          cmd_vld_0 = 1'b1;
        end
        do
          @(posedge clk);
        while (!(p ? cmd_ack_1 : cmd_ack_0));
        @(negedge clk);
        if (p)
          cmd_vld_1 = 1'b0;
        else
          cmd_vld_0 = 1'b0;
        if (!c[write_bit])
        begin
          do
            @(posedge clk);
          while (!(p ? (read_rdy_1 || read_err_1) : (read_rdy_0 || read_err_0)));
        end
      end
    end
  endtask

  task automatic take_frame(output logic [7:0] data);
    begin
      @(posedge clk);
      while (tx !== 1'b0 || !rst_n)
        @(posedge clk);
      repeat (clks_per_bit / 2 - 1 + clks_per_bit) @(posedge clk);
      for (int i = 0; i < 8; i++)
      begin
        data[i] = tx;
        repeat (clks_per_bit) @(posedge clk);
      end
      repeat (clks_per_bit) @(posedge clk);  // skip parity, stop at mid stop bit.
    end
  endtask

  task automatic send_reply(input logic [7:0] data, input logic bad);
    logic [10:0] f;
    begin
      f = {1'b1, (~^data) ^ bad, data, 1'b0};
      for (int i = 0; i < 11; i++)
      begin
        rx = f[i];
        repeat (clks_per_bit) @(negedge clk);
      end
    end
  endtask

  // register device on the far end of the link.
  initial
  begin : device
    logic [7:0]  b0;
    logic [7:0]  b1;
    int unsigned r;
    for (int i = 0; i < 128; i++)
      dev_regs[i] = 8'(i) ^ 8'ha5;
    wait (rst_n === 1'b1);
    forever
    begin
      take_frame(b0);
      if (b0[7])
      begin
        take_frame(b1);
        dev_regs[b0[6:0]] = b1;
      end
      else
      begin
        r            = $random(seed);
        reply_silent = (r % 10 == 0);
        reply_bad    = !reply_silent && ((r / 10) % 8 == 0);
        @(negedge clk);
        repeat (2 + (r / 80) % 150) @(negedge clk);
        if (!reply_silent)
          send_reply(dev_regs[b0[6:0]], reply_bad);
      end
    end
  end

  initial
  begin
    seed         = 7731;
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_in_0     = '0;
    cmd_in_1     = '0;
    cmd_vld_0    = 1'b0;
    cmd_vld_1    = 1'b0;
    rx           = 1'b1;
    reply_bad    = 1'b0;
    reply_silent = 1'b0;
    cycles       = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    fork
      issue_cmds(1'b0);
      issue_cmds(1'b1);
    join
    while (checked < 2 * num_cmds)
      @(posedge clk);
    repeat (20) @(posedge clk);
    $display("errors %0d, commands checked %0d", errors, checked);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/uart_cmd_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_checker #(
  parameter int clks_per_bit = 8,
  parameter int gap_cycles   = 5
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx,
  input  cmd_pkg::cmd_t        cmd_in_0,
  input  cmd_pkg::cmd_t        cmd_in_1,
  input  logic                 cmd_vld_0,
  input  logic                 cmd_vld_1,
  input  logic                 cmd_ack_0,
  input  logic                 cmd_ack_1,
  input  logic                 read_rdy_0,
  input  logic                 read_rdy_1,
  input  logic                 read_err_0,
  input  logic                 read_err_1,
  input  uart_link_pkg::byte_t read_data_0,
  input  uart_link_pkg::byte_t read_data_1,
  input  logic                 reply_bad,
  input  logic                 reply_silent,
  output int                   errors,
  output int                   checked
);
  import cmd_pkg::*;

  localparam int frame_len = 11 * clks_per_bit;

  logic [7:0] ref_regs [128];
  cmd_t       cmd_q [$];
  logic       port_q [$];
  int         ack_cyc_q [$];
  logic       rd_port_q [$];
  logic [7:0] rd_data_q [$];
  int         cyc;
  int         wr_done;
  int         rd_done;
  logic       last_g;
  logic       have_last;

  assign checked = wr_done + rd_done;

  initial
  begin
    errors    = 0;
    wr_done   = 0;
    rd_done   = 0;
    have_last = 1'b0;
    for (int i = 0; i < 128; i++)
      ref_regs[i] = 8'(i) ^ 8'ha5;  // same fill as the device.
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  // returns at the middle of the stop bit. t0 is the first low sample.
  task automatic get_frame(output logic [7:0] data, output int t0);
    logic [9:0] bits;
    logic       start_lvl;
    begin
      @(posedge clk);
      while (tx !== 1'b0 || !rst_n)
        @(posedge clk);
      t0 = cyc;
      repeat (clks_per_bit / 2 - 1) @(posedge clk);
      start_lvl = tx;
      for (int i = 0; i < 10; i++)
      begin
        repeat (clks_per_bit) @(posedge clk);
        bits[i] = tx;
      end
      data = bits[7:0];
      if (start_lvl !== 1'b0)
      begin
        $display("tx frame start bit was not low at mid bit");
        errors++;
      end
      if (^bits[8:0] !== 1'b1)
      begin
        $display("tx frame has wrong parity for byte %h", bits[7:0]);
        errors++;
      end
      if (bits[9] !== 1'b1)
      begin
        $display("tx frame stop bit was not high");
        errors++;
      end
    end
  endtask

  initial
  begin : tx_decode
    logic [7:0] b0;
    logic [7:0] b1;
    int         t0;
    int         t1;
    cmd_t       c;
    int         a_cyc;
    logic       port;
    forever
    begin
      get_frame(b0, t0);
      if (cmd_q.size() == 0)
      begin
        $display("frame on tx with no accepted command");
        errors++;
      end
      else
      begin
        c     = cmd_q.pop_front();
        a_cyc = ack_cyc_q.pop_front();
        port  = port_q.pop_front();
        if (t0 != a_cyc + 1)
        begin
          $display("first start bit began %0d cycles after the grant", t0 - a_cyc);
          errors++;
        end
        if (b0 !== c[15:8])
        begin
          $display("mismatch tx addr byte: got %h expected %h", b0, c[15:8]);
          errors++;
        end
        if (c[write_bit])
        begin
          get_frame(b1, t1);
          if (b1 !== c[7:0])
          begin
            $display("mismatch tx data byte: got %h expected %h", b1, c[7:0]);
            errors++;
          end
          if (t1 - t0 != frame_len + gap_cycles)
          begin
            $display("write gap was %0d idle cycles", t1 - t0 - frame_len);
            errors++;
          end
          ref_regs[c[14:8]] = c[7:0];
          wr_done++;
        end
        else
        begin
          rd_port_q.push_back(port);
          rd_data_q.push_back(ref_regs[c[14:8]]);
        end
      end
    end
  end

  always @(posedge clk)
  begin : grants
    logic g;
    logic want;
    if (rst_n && (cmd_ack_0 || cmd_ack_1))
    begin
      g    = cmd_ack_1;
      want = have_last ? !last_g : 1'b0;  // port 0 first after reset.
      if (cmd_ack_0 && cmd_ack_1)
      begin
        $display("both ports acknowledged in one cycle");
        errors++;
      end
      if (g ? !cmd_vld_1 : !cmd_vld_0)
      begin
        $display("acknowledge to a port that was not requesting");
        errors++;
      end
      if (cmd_vld_0 && cmd_vld_1 && g != want)
      begin
        $display("mismatch grant port: got %h expected %h", g, want);
        errors++;
      end
      cmd_q.push_back(g ? cmd_in_1 : cmd_in_0);
      port_q.push_back(g);
      ack_cyc_q.push_back(cyc);
      last_g    = g;
      have_last = 1'b1;
    end
  end

  always @(posedge clk)
  begin : results
    logic       p;
    logic [7:0] d;
    logic       rdy;
    logic       err;
    logic [7:0] got;
    if (rst_n && !have_last &&
        (tx !== 1'b1 || read_rdy_0 || read_rdy_1 || read_err_0 || read_err_1))
    begin
      $display("tx or a strobe was active before the first command");
      errors++;
    end
    if (rst_n && (read_rdy_0 || read_rdy_1 || read_err_0 || read_err_1))
    begin
      if (rd_port_q.size() == 0)
      begin
        $display("read result strobe with no pending read");
        errors++;
      end
      else
      begin
        p   = rd_port_q.pop_front();
        d   = rd_data_q.pop_front();
        rdy = p ? read_rdy_1 : read_rdy_0;
        err = p ? read_err_1 : read_err_0;
        got = p ? read_data_1 : read_data_0;
        if ((p ? (read_rdy_0 || read_err_0) : (read_rdy_1 || read_err_1)))
        begin
          $display("read result went to port %0d instead of port %0d", !p, p);
          errors++;
        end
        if (reply_bad || reply_silent)
        begin
          if (!err || rdy)
          begin
            $display("mismatch read_err: got %h expected %h", err, 1'b1);
            errors++;
          end
        end
        else if (!rdy || err)
        begin
          $display("mismatch read_rdy: got %h expected %h", rdy, 1'b1);
          errors++;
        end
        else if (got !== d)
        begin
          $display("mismatch read_data_%0d: got %h expected %h", p, got, d);
          errors++;
        end
        rd_done++;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top #(
  parameter int clks_per_bit = 8,
  parameter int gap_cycles   = 5,
  parameter int resp_timeout = 400
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::cmd_t        cmd_in_0,
  input  cmd_pkg::cmd_t        cmd_in_1,
  input  logic                 cmd_vld_0,
  input  logic                 cmd_vld_1,
  output logic                 cmd_ack_0,
  output logic                 cmd_ack_1,
  output logic                 read_rdy_0,
  output logic                 read_rdy_1,
  output logic                 read_err_0,
  output logic                 read_err_1,
  output uart_link_pkg::byte_t read_data_0,
  output uart_link_pkg::byte_t read_data_1,
  input  logic                 rx,
  output logic                 tx
);
  import uart_link_pkg::*;
  import cmd_pkg::*;

  logic  start;
  cmd_t  cmd;
  logic  busy;
  logic  done;
  logic  rd_valid;
  logic  rd_err;
  byte_t rd_byte;
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;
  logic  rx_done;
  byte_t rx_byte;
  logic  parity_err;
  logic  frame_err;

  cmd_arbiter arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in_0    (cmd_in_0),
    .cmd_in_1    (cmd_in_1),
    .cmd_vld_0   (cmd_vld_0),
    .cmd_vld_1   (cmd_vld_1),
    .cmd_ack_0   (cmd_ack_0),
    .cmd_ack_1   (cmd_ack_1),
    .busy        (busy),
    .start       (start),
    .cmd         (cmd),
    .done        (done),
    .rd_valid    (rd_valid),
    .rd_err      (rd_err),
    .rd_byte     (rd_byte),
    .read_rdy_0  (read_rdy_0),
    .read_rdy_1  (read_rdy_1),
    .read_err_0  (read_err_0),
    .read_err_1  (read_err_1),
    .read_data_0 (read_data_0),
    .read_data_1 (read_data_1)
  );

  uart_cmd_master #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles),
    .resp_timeout (resp_timeout)
  ) master_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cmd        (cmd),
    .busy       (busy),
    .done       (done),
    .rd_valid   (rd_valid),
    .rd_err     (rd_err),
    .rd_byte    (rd_byte),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

endmodule

`default_nettype wire

/* verilog/uart_cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_master #(
  parameter int clks_per_bit = 8,
  parameter int gap_cycles   = 5,  // two or more for an exact gap.
  parameter int resp_timeout = 400
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  cmd_pkg::cmd_t        cmd,
  output logic                 busy,
  output logic                 done,
  output logic                 rd_valid,
  output logic                 rd_err,
  output uart_link_pkg::byte_t rd_byte,
  output logic                 tx_start,
  output uart_link_pkg::byte_t tx_byte,
  input  logic                 tx_busy,
  input  logic                 rx_done,
  input  uart_link_pkg::byte_t rx_byte,
  input  logic                 parity_err,
  input  logic                 frame_err
);
  import uart_link_pkg::*;
  import cmd_pkg::*;

  // a start bit seen within resp_timeout still needs its frame and the
  // receiver synchronizer before rx_done.
  localparam int reply_limit = resp_timeout + frame_bits * clks_per_bit + 4;
  localparam int gap_w       = $clog2(gap_cycles + 1);
  localparam int wait_w      = $clog2(reply_limit + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_send_addr,
    st_gap,
    st_send_data,
    st_wait_reply,
    st_finish
  } state_t;

  state_t            state;
  logic              is_write_q;
  byte_t             data_q;
  logic              rd_valid_q;
  logic              rd_err_q;
  logic [gap_w-1:0]  gap_cnt;
  logic [wait_w-1:0] wait_cnt;
  addr_t             cmd_addr;
  logic              gap_last;
  logic              rx_bad;

  assign cmd_addr = cmd[write_bit-1 -: $bits(addr_t)];
  assign gap_last = (gap_cnt >= gap_w'(gap_cycles - 1));
  assign rx_bad   = parity_err || frame_err;

  assign busy     = (state != st_idle);
  assign done     = (state == st_finish);
  assign rd_valid = done && rd_valid_q;
  assign rd_err   = done && rd_err_q;

  // the address frame leaves in the grant cycle, the data frame at gap end.
  assign tx_start = (state == st_idle && start) || (state == st_gap && gap_last);
  assign tx_byte  = (state == st_idle) ? {cmd[write_bit], cmd_addr} : data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= st_idle;
      gap_cnt    <= '0;
      wait_cnt   <= '0;
      rd_valid_q <= 1'b0;
      rd_err_q   <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (start)
          begin
            rd_valid_q <= 1'b0;
            rd_err_q   <= 1'b0;
            state      <= st_send_addr;
          end
        end
        st_send_addr:
        begin
          if (!tx_busy)
          begin
            gap_cnt  <= gap_w'(1);  // this cycle is the first idle one.
            wait_cnt <= '0;
            state    <= is_write_q ? st_gap : st_wait_reply;
          end
        end
        st_gap:
        begin
          if (gap_last)
            state <= st_send_data;
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        st_send_data:
        begin
          if (!tx_busy)
            state <= st_finish;
        end
        st_wait_reply:
        begin
          if (rx_done)
          begin
            rd_valid_q <= !rx_bad;
            rd_err_q   <= rx_bad;
            state      <= st_finish;
          end
          else if (wait_cnt == wait_w'(reply_limit - 1))
          begin
            rd_err_q <= 1'b1;  // device stayed silent.
            state    <= st_finish;
          end
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        st_finish:
          state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle && start)
    begin
      is_write_q <= cmd[write_bit];
      data_q     <= cmd[$bits(byte_t)-1:0];
    end
    if (state == st_wait_reply && rx_done)
      rd_byte <= rx_byte;
  end

endmodule

`default_nettype wire

/* verilog/cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::cmd_t        cmd_in_0,
  input  cmd_pkg::cmd_t        cmd_in_1,
  input  logic                 cmd_vld_0,
  input  logic                 cmd_vld_1,
  output logic                 cmd_ack_0,
  output logic                 cmd_ack_1,
  input  logic                 busy,
  output logic                 start,
  output cmd_pkg::cmd_t        cmd,
  input  logic                 done,
  input  logic                 rd_valid,
  input  logic                 rd_err,
  input  uart_link_pkg::byte_t rd_byte,
  output logic                 read_rdy_0,
  output logic                 read_rdy_1,
  output logic                 read_err_0,
  output logic                 read_err_1,
  output uart_link_pkg::byte_t read_data_0,
  output uart_link_pkg::byte_t read_data_1
);
  import cmd_pkg::*;

  port_id_t prio;  // port that wins the next tie.
  port_id_t owner;
  port_id_t grant_id;

  always_comb
  begin
    if (prio == port_id_t'(0))
      grant_id = cmd_vld_0 ? port_id_t'(0) : port_id_t'(1);
    else
      grant_id = cmd_vld_1 ? port_id_t'(1) : port_id_t'(0);
  end

  assign start     = !busy && (cmd_vld_0 || cmd_vld_1);
  assign cmd_ack_0 = start && (grant_id == port_id_t'(0));
  assign cmd_ack_1 = start && (grant_id == port_id_t'(1));
  assign cmd       = (grant_id == port_id_t'(1)) ? cmd_in_1 : cmd_in_0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio  <= '0;
      owner <= '0;
    end
    else if (start)
    begin
      owner <= grant_id;
      prio  <= (grant_id == port_id_t'(num_ports - 1)) ? '0 : grant_id + 1'b1;
    end
  end

  // results go back to the port that issued the command.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_rdy_0 <= 1'b0;
      read_rdy_1 <= 1'b0;
      read_err_0 <= 1'b0;
      read_err_1 <= 1'b0;
    end
    else
    begin
      read_rdy_0 <= done && rd_valid && (owner == port_id_t'(0));
      read_rdy_1 <= done && rd_valid && (owner == port_id_t'(1));
      read_err_0 <= done && rd_err && (owner == port_id_t'(0));
      read_err_1 <= done && rd_err && (owner == port_id_t'(1));
    end
  end

  always_ff @(posedge clk)
  begin
    if (done && rd_valid && owner == port_id_t'(0))
      read_data_0 <= rd_byte;
    if (done && rd_valid && owner == port_id_t'(1))
      read_data_1 <= rd_byte;
  end

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int clks_per_bit = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 rx_done,
  output uart_link_pkg::byte_t rx_byte,
  output logic                 parity_err,
  output logic                 frame_err
);
  import uart_link_pkg::*;

  localparam int cnt_w    = $clog2(clks_per_bit + 1);
  localparam int half_bit = clks_per_bit / 2;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             active;
  logic [cnt_w-1:0] baud_cnt;
  logic [cnt_w-1:0] sample_at;
  bit_idx_t         bit_idx;
  byte_t            shift_q;
  logic             par_q;
  logic             sample;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // the start bit is checked at half a bit time, the rest a full bit apart.
  assign sample_at = (bit_idx == '0) ? cnt_w'(half_bit - 1) : cnt_w'(clks_per_bit - 1);
  assign sample    = active && (baud_cnt == sample_at);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active     <= 1'b0;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      rx_done    <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!active)
      begin
        baud_cnt <= '0;
        bit_idx  <= '0;
        if (rx_prev && !rx_sync)
          active <= 1'b1;
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0)
        begin
          if (rx_sync)
            active <= 1'b0;  // glitch, not a start bit.
        end
        else if (bit_idx == bit_idx_t'(frame_bits - 1))
        begin
          active     <= 1'b0;
          rx_done    <= 1'b1;
          parity_err <= ~^{shift_q, par_q};
          frame_err  <= ~rx_sync;
        end
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && bit_idx != '0 && bit_idx <= bit_idx_t'(data_bits))
      shift_q <= {rx_sync, shift_q[data_bits-1:1]};  // lsb arrives first.
    if (sample && bit_idx == bit_idx_t'(data_bits + 1))
      par_q <= rx_sync;
    if (sample && bit_idx == bit_idx_t'(frame_bits - 1))
      rx_byte <= shift_q;
  end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  uart_link_pkg::byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_busy
);
  import uart_link_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  logic [cnt_w-1:0] baud_cnt;
  bit_idx_t         bit_idx;
  byte_t            data_q;
  logic             bit_end;
  logic             next_bit;

  assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));

  // level of the bit that follows the current one.
  always_comb
  begin
    next_bit = 1'b1;
    if (bit_idx < bit_idx_t'(data_bits))
      next_bit = data_q[bit_idx[$clog2(data_bits)-1:0]];
    else if (bit_idx == bit_idx_t'(data_bits))
      next_bit = ~^data_q;  // odd parity.
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy  <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!tx_busy)
    begin
      baud_cnt <= '0;
      bit_idx  <= '0;
      if (tx_start)
      begin
        tx_busy <= 1'b1;
        tx      <= 1'b0;  // start bit.
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == bit_idx_t'(frame_bits - 1))
        tx_busy <= 1'b0;  // line is left high by the stop bit.
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= next_bit;
      end
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
      data_q <= tx_byte;
  end

endmodule

`default_nettype wire

/* verilog/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

  // {write flag, 7-bit address, write data}.
  typedef logic [15:0] cmd_t;

  localparam int write_bit = 15;

  typedef logic [6:0] addr_t;

  localparam int num_ports = 2;

  typedef logic [$clog2(num_ports)-1:0] port_id_t;

endpackage

`default_nettype wire

/* verilog/uart_link_pkg.sv */
`default_nettype none

package uart_link_pkg;

  // one serial payload.
  typedef logic [7:0] byte_t;

  localparam int data_bits = 8;

  // start, eight data bits, odd parity, stop.
  localparam int frame_bits = 11;

  // position within a frame, 0 is the start bit.
  typedef logic [3:0] bit_idx_t;

endpackage

`default_nettype wire
